// File: test/ddr_bridge_stim.txt
# op addr wdata sel exp_data exp_err in hex
# W writes and R reads, P sets phy_ready_i to wdata bit 0
# expected data applies to reads and error responses
P 00000000 0001 0 0000 0
R 00020000 0000 0 dd52 0
R 00020002 0000 0 0001 0
P 00000000 0000 0 0000 0
R 00020002 0000 0 0000 0
P 00000000 0001 0 0000 0
R 00020006 0000 0 0000 0
W 00020004 ab05 1 0000 0
R 00020004 0000 0 0005 0
W 00020004 0f07 2 0000 0
R 00020004 0000 0 0005 0
W 00020004 0001 3 0000 0
W 00030010 1234 3 0000 0
W 0003001e 5678 3 0000 0
W 00030016 9abc 3 0000 0
W 00020004 0002 3 0000 0
W 00030010 4321 3 0000 0
W 00030ff2 beef 3 0000 0
R 00030ff2 0000 0 beef 0
R 00030010 0000 0 4321 0
W 00020004 0001 3 0000 0
R 00030010 0000 0 1234 0
R 0003001e 0000 0 5678 0
R 00030016 0000 0 9abc 0
W 0003001e 3300 2 0000 0
R 0003001e 0000 0 3378 0
R 00030016 0000 0 9abc 0
P 00000000 0000 0 0000 0
W 00030010 1111 3 0000 1
R 00030010 0000 0 0000 1
P 00000000 0001 0 0000 0
R 00030010 0000 0 1234 0
R 00040000 0000 0 0000 1
W 00010000 5555 3 0000 1
R 00020000 0000 0 dd52 0

// File: vlog.f
hw/ddr_bridge_pkg.sv
hw/bus_decoder.sv
hw/ctrl_regs.sv
hw/ddr_mem_port.sv
hw/rsp_merge.sv
hw/ddr_bridge_top.sv
test/tb_clock_gen.sv
test/tb_ddr_bridge.sv

// File: Makefile
TOP := tb_ddr_bridge

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module ddr_bridge_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: test/tb_ddr_bridge.sv
`timescale 1ns/1ps

module tb_ddr_bridge;
  import ddr_bridge_pkg::*;

  localparam int PAGE_BITS      = 8;
  localparam int TIMEOUT_CYCLES = 400;

  logic      ddr_clk_0;
  logic      reset_i;
  logic      req_valid_i;
  logic      req_ready_o;
  logic      req_we_i;
  bus_addr_t req_addr_i;
  bus_data_t req_wdata_i;
  bus_sel_t  req_sel_i;
  logic      rsp_valid_o;
  logic      rsp_ready_i = 1'b1;
  bus_data_t rsp_data_o;
  logic      rsp_err_o;
  ddr_cmd_t  af_cmd_o;
  ddr_addr_t af_addr_o;
  logic      af_wren_o;
  logic      af_afull_i = 1'b0;
  ddr_data_t df_data_o;
  ddr_mask_t df_mask_o;
  logic      df_wren_o;
  logic      df_afull_i = 1'b0;
  ddr_data_t rd_data_i = '0;
  logic      rd_dvalid_i = 1'b0;
  logic      phy_ready_i;

  // application side model of the controller
  ddr_data_t   line_store [ddr_addr_t];
  ddr_addr_t   wr_line = '0;
  int          wr_beat = 2;
  ddr_addr_t   rd_line = '0;
  int          rd_left = 0;
  int          rd_wait = 0;
  logic [31:0] lfsr = 32'h1f4a;

  // what the next DDR command should look like
  logic [PAGE_BITS-1:0] page_model = '0;
  ddr_addr_t            exp_line = '0;
  ddr_cmd_t             exp_cmd = DDR_CMD_READ;

  tb_clock_gen u_clock_gen (.clk_o(ddr_clk_0), .reset_o(reset_i));

  ddr_bridge_top #(.PAGE_BITS(PAGE_BITS)) dut_i (
    .ddr_clk_0(ddr_clk_0), .reset_i(reset_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_we_i(req_we_i),
    .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i), .req_sel_i(req_sel_i),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i),
    .rsp_data_o(rsp_data_o), .rsp_err_o(rsp_err_o),
    .af_cmd_o(af_cmd_o), .af_addr_o(af_addr_o), .af_wren_o(af_wren_o),
    .af_afull_i(af_afull_i),
    .df_data_o(df_data_o), .df_mask_o(df_mask_o), .df_wren_o(df_wren_o),
    .df_afull_i(df_afull_i),
    .rd_data_i(rd_data_i), .rd_dvalid_i(rd_dvalid_i), .phy_ready_i(phy_ready_i)
  );

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    end_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
      end_with_failure();
    end
  endtask

  // fibonacci, taps 32 22 2 1
  function automatic logic lfsr_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic ddr_data_t line_value(input ddr_addr_t addr);
    if (line_store.exists(addr)) return line_store[addr];
    else return '0;   // never written
  endfunction

  task automatic store_word(input ddr_addr_t addr, input ddr_data_t data, input ddr_mask_t mask);
    ddr_data_t cur;
    cur = line_value(addr);
    for (int b = 0; b < 16; b++) begin
      if (!mask[b]) cur[8*b +: 8] = data[8*b +: 8];
    end
    line_store[addr] = cur;
  endtask

  // page register at index 2 of the register region, byte selects apply
  task automatic track_page(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] sel);
    if (addr[31:16] == REG_BASE[31:16] && addr[3:1] == REG_IDX_PAGE) begin
      for (int i = 0; i < PAGE_BITS; i++) begin
        if (sel[i / 8]) page_model[i] = wdata[i];
      end
    end
  endtask

  task automatic check_response(input logic we, input logic [31:0] exp_data,
                                input logic [31:0] exp_err);
    check_value("rsp_err_o", 32'(rsp_err_o), exp_err);
    if (!we || exp_err != 0) check_value("rsp_data_o", 32'(rsp_data_o), exp_data);
  endtask

  task automatic do_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [31:0] sel, input logic [31:0] exp_data,
                           input logic [31:0] exp_err);
    int waited;
    exp_cmd  = we ? DDR_CMD_WRITE : DDR_CMD_READ;
    // page above the 16 byte line index, three zero bits below
    exp_line = (ddr_addr_t'(page_model) << 15) | (ddr_addr_t'(addr[15:4]) << 3);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata[15:0];
    req_sel_i   = sel[1:0];
    waited = 0;
    @(posedge ddr_clk_0);
    while (!req_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_failure("timeout, req_ready_o never went high");
      @(posedge ddr_clk_0);
    end
    #1 req_valid_i = 1'b0;
    waited = 0;
    @(posedge ddr_clk_0);
    while (!rsp_valid_o) begin
      check_value("req_ready_o", 32'(req_ready_o), 32'h0);   // busy until response taken
      waited++;
      if (waited > TIMEOUT_CYCLES) report_failure("timeout, no rsp_valid_o for the request");
      @(posedge ddr_clk_0);
    end
    check_response(we, exp_data, exp_err);
    waited = 0;
    while (!rsp_ready_i) begin
      check_value("req_ready_o", 32'(req_ready_o), 32'h0);
      waited++;
      if (waited > TIMEOUT_CYCLES) report_failure("timeout, rsp_ready_i stayed low");
      @(posedge ddr_clk_0);
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h1);
      check_response(we, exp_data, exp_err);
    end
    #1;
  endtask

  // samples at the edge, drives 1 ns later
  always @(posedge ddr_clk_0) begin
    if (!reset_i && af_wren_o) begin
      if (!phy_ready_i) report_failure("DDR command issued while phy_ready_i was low");
      if (af_afull_i) report_failure("command FIFO written while af_afull_i was high");
      if (wr_beat != 2) report_failure("write burst did not send exactly two data words");
      check_value("af_cmd_o", 32'(af_cmd_o), 32'(exp_cmd));
      check_value("af_addr_o", 32'(af_addr_o), 32'(exp_line));
      if (af_cmd_o == DDR_CMD_WRITE) begin
        wr_line = af_addr_o;
        wr_beat = 0;
      end else begin
        rd_line = af_addr_o;
        rd_left = 2;
        rd_wait = 2 + 2 * int'(lfsr_bit()) + int'(lfsr_bit());
      end
    end
    if (!reset_i && df_wren_o) begin
      if (df_afull_i) report_failure("data FIFO written while df_afull_i was high");
      if (wr_beat == 0) store_word(wr_line, df_data_o, df_mask_o);
      else check_value("df_mask_o", 32'(df_mask_o), 32'h0000_ffff);
      wr_beat++;
    end
    #1;
    rd_dvalid_i = 1'b0;
    if (rd_left > 0) begin
      if (rd_wait > 0) begin
        rd_wait--;
      end else begin
        rd_dvalid_i = 1'b1;
        rd_data_i   = (rd_left == 2) ? line_value(rd_line) : ~line_value(rd_line);
        rd_left--;
        rd_wait     = int'(lfsr_bit());
      end
    end
    af_afull_i  = lfsr_bit() & lfsr_bit();
    df_afull_i  = lfsr_bit() & lfsr_bit();
    rsp_ready_i = lfsr_bit() | lfsr_bit();
  end

  initial begin : stimulus
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] sel;
    logic [31:0] exp_data;
    logic [31:0] exp_err;
    int          fd;
    int          fields;
    int          waited;
    int          n_ops;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_sel_i   = '0;
    phy_ready_i = 1'b1;
    waited = 0;
    @(posedge ddr_clk_0);
    while (reset_i) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) report_failure("timeout, reset_i never released");
      @(posedge ddr_clk_0);
    end
    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    #1;
    fd = $fopen("test/ddr_bridge_stim.txt", "r");
    if (fd == 0) report_failure("cannot open test/ddr_bridge_stim.txt");
    n_ops = 0;
    while (!$feof(fd)) begin
      line = "";
      fields = $fgets(line, fd);
      if (fields > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, sel, exp_data, exp_err);
        if (fields != 6) report_failure({"malformed stimulus line ", line});
        case (op)
          "W": begin
            do_access(1'b1, addr, wdata, sel, exp_data, exp_err);
            track_page(addr, wdata, sel);
          end
          "R": do_access(1'b0, addr, wdata, sel, exp_data, exp_err);
          "P": begin
            phy_ready_i = wdata[0];
            @(posedge ddr_clk_0);
            #1;
          end
          default: report_failure({"unknown operation in stimulus line ", line});
        endcase
        n_ops++;
      end
    end
    $fclose(fd);
    if (n_ops == 0) begin
      report_failure("stimulus file holds no operations");
    end else begin
      $display("%0d operations done", n_ops);
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD_NS = 4,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;   // same skew as the other inputs
  end

endmodule

// File: hw/ddr_bridge_top.sv
`timescale 1ns/1ps

module ddr_bridge_top #(
  parameter int PAGE_BITS = $bits(ddr_bridge_pkg::page_t)
) (
  input  logic                      ddr_clk_0,
  input  logic                      reset_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  ddr_bridge_pkg::bus_addr_t req_addr_i,
  input  ddr_bridge_pkg::bus_data_t req_wdata_i,
  input  ddr_bridge_pkg::bus_sel_t  req_sel_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output ddr_bridge_pkg::bus_data_t rsp_data_o,
  output logic                      rsp_err_o,
  output ddr_bridge_pkg::ddr_cmd_t  af_cmd_o,
  output ddr_bridge_pkg::ddr_addr_t af_addr_o,
  output logic                      af_wren_o,
  input  logic                      af_afull_i,
  output ddr_bridge_pkg::ddr_data_t df_data_o,
  output ddr_bridge_pkg::ddr_mask_t df_mask_o,
  output logic                      df_wren_o,
  input  logic                      df_afull_i,
  input  ddr_bridge_pkg::ddr_data_t rd_data_i,
  input  logic                      rd_dvalid_i,
  input  logic                      phy_ready_i
);
  import ddr_bridge_pkg::*;

  logic                 reg_sel;
  logic                 mem_sel;
  logic                 decode_err;
  logic                 acc_we;
  bus_addr_t            acc_addr;
  bus_data_t            acc_wdata;
  bus_sel_t             acc_sel;
  logic                 reg_done;
  bus_data_t            reg_rdata;
  logic [PAGE_BITS-1:0] page;
  logic                 mem_done;
  bus_data_t            mem_rdata;
  logic                 mem_err;
  logic                 rsp_fire;

  bus_decoder u_bus_decoder (
    .ddr_clk_0(ddr_clk_0), .reset_i(reset_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .req_we_i(req_we_i), .req_addr_i(req_addr_i),
    .req_wdata_i(req_wdata_i), .req_sel_i(req_sel_i),
    .rsp_fire_i(rsp_fire),
    .reg_sel_o(reg_sel), .mem_sel_o(mem_sel), .decode_err_o(decode_err),
    .acc_we_o(acc_we), .acc_addr_o(acc_addr),
    .acc_wdata_o(acc_wdata), .acc_sel_o(acc_sel)
  );

  ctrl_regs #(
    .PAGE_BITS(PAGE_BITS)
  ) u_ctrl_regs (
    .ddr_clk_0(ddr_clk_0), .reset_i(reset_i),
    .reg_sel_i(reg_sel), .acc_we_i(acc_we), .acc_addr_i(acc_addr),
    .acc_wdata_i(acc_wdata), .acc_sel_i(acc_sel),
    .phy_ready_i(phy_ready_i),
    .reg_done_o(reg_done), .reg_rdata_o(reg_rdata), .page_o(page)
  );

  ddr_mem_port #(
    .PAGE_BITS(PAGE_BITS)
  ) u_ddr_mem_port (
    .ddr_clk_0(ddr_clk_0), .reset_i(reset_i),
    .mem_sel_i(mem_sel), .acc_we_i(acc_we), .acc_addr_i(acc_addr),
    .acc_wdata_i(acc_wdata), .acc_sel_i(acc_sel), .page_i(page),
    .af_cmd_o(af_cmd_o), .af_addr_o(af_addr_o), .af_wren_o(af_wren_o),
    .af_afull_i(af_afull_i),
    .df_data_o(df_data_o), .df_mask_o(df_mask_o), .df_wren_o(df_wren_o),
    .df_afull_i(df_afull_i),
    .rd_data_i(rd_data_i), .rd_dvalid_i(rd_dvalid_i), .phy_ready_i(phy_ready_i),
    .mem_done_o(mem_done), .mem_rdata_o(mem_rdata), .mem_err_o(mem_err)
  );

  rsp_merge u_rsp_merge (
    .ddr_clk_0(ddr_clk_0), .reset_i(reset_i),
    .reg_done_i(reg_done), .reg_rdata_i(reg_rdata),
    .mem_done_i(mem_done), .mem_rdata_i(mem_rdata), .mem_err_i(mem_err),
    .decode_err_i(decode_err),
    .rsp_ready_i(rsp_ready_i), .rsp_valid_o(rsp_valid_o),
    .rsp_data_o(rsp_data_o), .rsp_err_o(rsp_err_o), .rsp_fire_o(rsp_fire)
  );

endmodule

// File: hw/rsp_merge.sv
`timescale 1ns/1ps

module rsp_merge (
  input  logic                      ddr_clk_0,
  input  logic                      reset_i,
  input  logic                      reg_done_i,
  input  ddr_bridge_pkg::bus_data_t reg_rdata_i,
  input  logic                      mem_done_i,
  input  ddr_bridge_pkg::bus_data_t mem_rdata_i,
  input  logic                      mem_err_i,
  input  logic                      decode_err_i,
  input  logic                      rsp_ready_i,
  output logic                      rsp_valid_o,
  output ddr_bridge_pkg::bus_data_t rsp_data_o,
  output logic                      rsp_err_o,
  output logic                      rsp_fire_o
);
  import ddr_bridge_pkg::*;

  logic any_done;
  logic err_in;

  assign any_done   = reg_done_i || mem_done_i || decode_err_i;
  assign err_in     = decode_err_i || (mem_done_i && mem_err_i);
  assign rsp_fire_o = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge ddr_clk_0) begin
    if (reset_i) begin
      rsp_valid_o <= 1'b0;
    end else if (any_done) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_fire_o) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge ddr_clk_0) begin
    if (any_done) begin
      rsp_err_o <= err_in;
      if (err_in) rsp_data_o <= '0;
      else if (mem_done_i) rsp_data_o <= mem_rdata_i;
      else rsp_data_o <= reg_rdata_i;
    end
  end

  // only one access in flight across decoder, regs and mem port
  a_one_source: assert property (@(posedge ddr_clk_0) disable iff (reset_i)
    $onehot0({reg_done_i, mem_done_i, decode_err_i}));

  a_rsp_hold: assert property (@(posedge ddr_clk_0) disable iff (reset_i)
    (rsp_valid_o && !rsp_ready_i) |=>
      (rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_err_o)));

endmodule

// File: hw/ddr_mem_port.sv
`timescale 1ns/1ps

module ddr_mem_port #(
  parameter int PAGE_BITS = $bits(ddr_bridge_pkg::page_t)
) (
  input  logic                      ddr_clk_0,
  input  logic                      reset_i,
  input  logic                      mem_sel_i,
  input  logic                      acc_we_i,
  input  ddr_bridge_pkg::bus_addr_t acc_addr_i,
  input  ddr_bridge_pkg::bus_data_t acc_wdata_i,
  input  ddr_bridge_pkg::bus_sel_t  acc_sel_i,
  input  logic [PAGE_BITS-1:0]      page_i,
  output ddr_bridge_pkg::ddr_cmd_t  af_cmd_o,
  output ddr_bridge_pkg::ddr_addr_t af_addr_o,
  output logic                      af_wren_o,
  input  logic                      af_afull_i,
  output ddr_bridge_pkg::ddr_data_t df_data_o,
  output ddr_bridge_pkg::ddr_mask_t df_mask_o,
  output logic                      df_wren_o,
  input  logic                      df_afull_i,
  input  ddr_bridge_pkg::ddr_data_t rd_data_i,
  input  logic                      rd_dvalid_i,
  input  logic                      phy_ready_i,
  output logic                      mem_done_o,
  output ddr_bridge_pkg::bus_data_t mem_rdata_o,
  output logic                      mem_err_o
);
  import ddr_bridge_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_DATA0,
    ST_DATA1,
    ST_RD0,
    ST_RD1,
    ST_DONE
  } state_t;

  state_t    state_q;
  lane_t     lane;
  ddr_data_t line_data;
  ddr_mask_t line_mask;

  assign lane = acc_addr_i[3:1];

  // page above the line index, burst of four so 3 low zero bits
  assign af_addr_o = ddr_addr_t'({page_i, acc_addr_i[15:4], 3'b000});
  assign af_cmd_o  = acc_we_i ? DDR_CMD_WRITE : DDR_CMD_READ;

  assign line_data = ddr_data_t'(acc_wdata_i) << {lane, 4'b0000};
  assign line_mask = ~(ddr_mask_t'(acc_sel_i) << {lane, 1'b0});

  // second word of the burst carries nothing
  assign df_data_o = (state_q == ST_DATA0) ? line_data : '0;
  assign df_mask_o = (state_q == ST_DATA0) ? line_mask : '1;

  assign af_wren_o  = (state_q == ST_CMD) && !af_afull_i;
  assign df_wren_o  = ((state_q == ST_DATA0) || (state_q == ST_DATA1)) && !df_afull_i;
  assign mem_done_o = (state_q == ST_DONE);

  always_ff @(posedge ddr_clk_0) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      mem_err_o <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (mem_sel_i) begin
            mem_err_o <= !phy_ready_i;
            state_q   <= phy_ready_i ? ST_CMD : ST_DONE;   // no DDR traffic if not ready
          end
        end
        ST_CMD: begin
          if (!af_afull_i) state_q <= acc_we_i ? ST_DATA0 : ST_RD0;
        end
        ST_DATA0: begin
          if (!df_afull_i) state_q <= ST_DATA1;
        end
        ST_DATA1: begin
          if (!df_afull_i) state_q <= ST_DONE;
        end
        ST_RD0: begin
          if (rd_dvalid_i) state_q <= ST_RD1;
        end
        ST_RD1: begin
          if (rd_dvalid_i) state_q <= ST_DONE;   // second word dropped
        end
        ST_DONE: state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge ddr_clk_0) begin
    if (state_q == ST_IDLE && mem_sel_i) begin
      mem_rdata_o <= '0;                                // writes answer zero
    end else if (state_q == ST_RD0 && rd_dvalid_i) begin
      mem_rdata_o <= rd_data_i[{lane, 4'b0000} +: 16];
    end
  end

  // a new access only lands on an idle port
  a_sel_idle: assert property (@(posedge ddr_clk_0) disable iff (reset_i)
    mem_sel_i |-> (state_q == ST_IDLE));

  a_rd_expected: assert property (@(posedge ddr_clk_0) disable iff (reset_i)
    rd_dvalid_i |-> (state_q == ST_RD0 || state_q == ST_RD1));   // no stray read data

endmodule

// File: hw/ctrl_regs.sv
`timescale 1ns/1ps

module ctrl_regs #(
  parameter int PAGE_BITS = $bits(ddr_bridge_pkg::page_t)
) (
  input  logic                      ddr_clk_0,
  input  logic                      reset_i,
  input  logic                      reg_sel_i,
  input  logic                      acc_we_i,
  input  ddr_bridge_pkg::bus_addr_t acc_addr_i,
  input  ddr_bridge_pkg::bus_data_t acc_wdata_i,
  input  ddr_bridge_pkg::bus_sel_t  acc_sel_i,
  input  logic                      phy_ready_i,
  output logic                      reg_done_o,
  output ddr_bridge_pkg::bus_data_t reg_rdata_o,
  output logic [PAGE_BITS-1:0]      page_o
);
  import ddr_bridge_pkg::*;

  reg_idx_t idx;
  logic     page_wr;

  assign idx     = acc_addr_i[3:1];
  assign page_wr = reg_sel_i && acc_we_i && (idx == REG_IDX_PAGE);

  always_ff @(posedge ddr_clk_0) begin
    if (reset_i) begin
      reg_done_o <= 1'b0;
      page_o     <= '0;
    end else begin
      reg_done_o <= reg_sel_i;
      if (page_wr) begin
        for (int i = 0; i < PAGE_BITS; i++) begin
          if (acc_sel_i[i / 8]) page_o[i] <= acc_wdata_i[i];   // per byte lane
        end
      end
    end
  end

  // read mux, other writes just complete
  always_ff @(posedge ddr_clk_0) begin
    if (reg_sel_i) begin
      case (idx)
        REG_IDX_ID:     reg_rdata_o <= BRIDGE_ID;
        REG_IDX_STATUS: reg_rdata_o <= bus_data_t'(phy_ready_i);
        REG_IDX_PAGE:   reg_rdata_o <= bus_data_t'(page_o);
        default:        reg_rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: hw/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
  input  logic                      ddr_clk_0,
  input  logic                      reset_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  ddr_bridge_pkg::bus_addr_t req_addr_i,
  input  ddr_bridge_pkg::bus_data_t req_wdata_i,
  input  ddr_bridge_pkg::bus_sel_t  req_sel_i,
  input  logic                      rsp_fire_i,
  output logic                      reg_sel_o,
  output logic                      mem_sel_o,
  output logic                      decode_err_o,
  output logic                      acc_we_o,
  output ddr_bridge_pkg::bus_addr_t acc_addr_o,
  output ddr_bridge_pkg::bus_data_t acc_wdata_o,
  output ddr_bridge_pkg::bus_sel_t  acc_sel_o
);
  import ddr_bridge_pkg::*;

  typedef enum logic {ST_IDLE, ST_BUSY} state_t;

  state_t state_q;
  logic   accept;
  logic   hit_reg;
  logic   hit_mem;

  assign req_ready_o = (state_q == ST_IDLE);
  assign accept      = req_valid_i && req_ready_o;
  assign hit_reg     = region_hit(req_addr_i, REG_BASE);
  assign hit_mem     = region_hit(req_addr_i, MEM_BASE);

  always_ff @(posedge ddr_clk_0) begin
    if (reset_i) begin
      state_q      <= ST_IDLE;
      reg_sel_o    <= 1'b0;
      mem_sel_o    <= 1'b0;
      decode_err_o <= 1'b0;
    end else begin
      reg_sel_o    <= accept && hit_reg;
      mem_sel_o    <= accept && hit_mem;
      decode_err_o <= accept && !hit_reg && !hit_mem;   // unmapped
      case (state_q)
        ST_IDLE: if (accept) state_q <= ST_BUSY;
        ST_BUSY: if (rsp_fire_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request held here until the next accept
  always_ff @(posedge ddr_clk_0) begin
    if (accept) begin
      acc_we_o    <= req_we_i;
      acc_addr_o  <= req_addr_i;
      acc_wdata_o <= req_wdata_i;
      acc_sel_o   <= req_sel_i;
    end
  end

  // a response only ends an access that is in flight
  a_fire_busy: assert property (@(posedge ddr_clk_0) disable iff (reset_i)
    rsp_fire_i |-> (state_q == ST_BUSY));

endmodule

// File: hw/ddr_bridge_pkg.sv
package ddr_bridge_pkg;

  // host bus
  typedef logic [31:0] bus_addr_t;
  typedef logic [15:0] bus_data_t;
  typedef logic [1:0]  bus_sel_t;

  // controller application side
  typedef logic [30:0]  ddr_addr_t;
  typedef logic [127:0] ddr_data_t;
  typedef logic [15:0]  ddr_mask_t;   // set bit = byte not written
  typedef logic [2:0]   ddr_cmd_t;

  typedef logic [7:0] page_t;

  // halfword lane within a 16 byte line, also the register index
  typedef logic [2:0] lane_t;
  typedef logic [2:0] reg_idx_t;

  localparam ddr_cmd_t DDR_CMD_WRITE = 3'd0;
  localparam ddr_cmd_t DDR_CMD_READ  = 3'd1;

  // 64 KB regions, bits 31:16 select
  localparam bus_addr_t REG_BASE = 32'h0002_0000;
  localparam bus_addr_t MEM_BASE = 32'h0003_0000;

  localparam bus_data_t BRIDGE_ID = 16'hDD52;

  localparam reg_idx_t REG_IDX_ID     = 3'd0;
  localparam reg_idx_t REG_IDX_STATUS = 3'd1;
  localparam reg_idx_t REG_IDX_PAGE   = 3'd2;

  function automatic logic region_hit(bus_addr_t addr, bus_addr_t base);
    return addr[31:16] == base[31:16];
  endfunction

endpackage
